// ==== controlDecoder.sv ====
//======================================================================
// main control and ALU control decode, destination register select
//======================================================================
`timescale 1ns/100ps

module controlDecoder
  import mipsIsaPkg::*, mipsCtrlPkg::*;
(
  input  logic [dataWidth-1:0] instr,
  decodeIf.decoder             dec
);

  logic [opWidth-1:0]      opcode;
  logic [fnWidth-1:0]      funct;
  logic [regAddrWidth-1:0] rtField;
  logic [regAddrWidth-1:0] rdField;
  logic                    wrReq;
  logic [regAddrWidth-1:0] destSel;

  // instruction fields
  assign opcode       = instr[opMsb:opLsb];
  assign funct        = instr[fnMsb:fnLsb];
  assign rtField      = instr[rtMsb:rtLsb];
  assign rdField      = instr[rdMsb:rdLsb];
  assign dec.imm16    = instr[immWidth-1:0];
  assign dec.target26 = instr[targetWidth-1:0];

  always_comb begin
    // default is no write, no flow change and add for address math
    dec.aluOp     = aluAdd;
    dec.wbSrc     = wbAlu;
    dec.aluSrcImm = 1'b0;
    dec.memWrite  = 1'b0;
    dec.branch    = 1'b0;
    dec.jump      = 1'b0;
    dec.jumpReg   = 1'b0;
    wrReq         = 1'b0;
    destSel       = rdField;
    case (opcode)
      opR: begin
        wrReq = 1'b1;
        case (funct)
          fnAdd: dec.aluOp = aluAdd;
          fnSub: dec.aluOp = aluSub;
          fnAnd: dec.aluOp = aluAnd;
          fnOr:  dec.aluOp = aluOr;
          fnSlt: dec.aluOp = aluSlt;
          // jr takes its target from rs and writes nothing
          fnJr: begin
            wrReq       = 1'b0;
            dec.jumpReg = 1'b1;
          end
          default: wrReq = 1'b0;
        endcase
      end
      opLw: begin
        wrReq         = 1'b1;
        dec.aluSrcImm = 1'b1;
        dec.wbSrc     = wbMem;
        destSel       = rtField;
      end
      opSw: begin
        dec.memWrite  = 1'b1;
        dec.aluSrcImm = 1'b1;
      end
      opBeq: begin
        // compare by subtract, zero flag steers pc
        dec.branch = 1'b1;
        dec.aluOp  = aluSub;
      end
      opJ: dec.jump = 1'b1;
      opJal: begin
        dec.jump  = 1'b1;
        wrReq     = 1'b1;
        dec.wbSrc = wbLink;
        destSel   = linkReg;
      end
      // unknown opcode changes nothing but the pc
      default: ;
    endcase
  end

  // writes aimed at r0 never reach the write port
  assign dec.destReg  = destSel;
  assign dec.regWrite = wrReq && (destSel != '0);

endmodule

// ==== decodeIf.sv ====
//======================================================================
// decoded control bundle from the decoder to fetch, execute, regs
//======================================================================
`timescale 1ns/100ps

interface decodeIf
  import mipsIsaPkg::*, mipsCtrlPkg::*;
();

  aluOpT                   aluOp;
  wbSrcT                   wbSrc;
  logic                    aluSrcImm;
  logic                    regWrite;
  logic                    memWrite;
  logic                    branch;
  logic                    jump;
  logic                    jumpReg;
  // already resolved between rd, rt and r31
  logic [regAddrWidth-1:0] destReg;
  logic [immWidth-1:0]     imm16;
  logic [targetWidth-1:0]  target26;

  modport decoder (output aluOp, wbSrc, aluSrcImm, regWrite, memWrite,
                   branch, jump, jumpReg, destReg, imm16, target26);
  modport fetch   (input branch, jump, jumpReg, imm16, target26);
  modport exec    (input aluOp, aluSrcImm, wbSrc, imm16);
  modport regs    (input regWrite, destReg);

endinterface

// ==== executeUnit.sv ====
//======================================================================
// sign extend, operand select, ALU, zero flag, write-back select
//======================================================================
`timescale 1ns/100ps

module executeUnit
  import mipsIsaPkg::*, mipsCtrlPkg::*;
(
  decodeIf.exec                dec,
  input  logic [dataWidth-1:0] rsData,
  input  logic [dataWidth-1:0] rtData,
  input  logic [dataWidth-1:0] memRdata,
  input  logic [dataWidth-1:0] linkAddr,
  output logic [dataWidth-1:0] aluResult,
  output logic [dataWidth-1:0] wrData,
  output logic                 zero
);

  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] opB;
  logic [dataWidth-1:0] diff;

  // lw/sw offset
  assign immExt = {{(dataWidth-immWidth){dec.imm16[immWidth-1]}}, dec.imm16};
  assign opB    = dec.aluSrcImm ? immExt : rtData;

  // shared by sub and the beq compare
  assign diff = rsData - opB;
  assign zero = (diff == '0);

  //====================================================================
  // ALU
  //====================================================================
  always_comb begin
    case (dec.aluOp)
      aluAdd:  aluResult = rsData + opB;
      aluSub:  aluResult = diff;
      aluAnd:  aluResult = rsData & opB;
      aluOr:   aluResult = rsData | opB;
      // unsigned less-than
      aluSlt:  aluResult = (rsData < opB) ? 32'd1 : 32'd0;
      default: aluResult = '0;
    endcase
  end

  // register write data
  always_comb begin
    case (dec.wbSrc)
      wbAlu:   wrData = aluResult;
      wbMem:   wrData = memRdata;
      wbLink:  wrData = linkAddr;
      default: wrData = aluResult;
    endcase
  end

endmodule

// ==== mipsCore.sv ====
//======================================================================
// single-cycle MIPS subset core, memory and observation ports
//======================================================================
`timescale 1ns/100ps

module mipsCore
  import mipsIsaPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  // instruction memory
  output logic [dataWidth-1:0]     instrAddr,
  input  logic [dataWidth-1:0]     instr,
  // data memory, word addressed
  output logic [dmemAddrWidth-1:0] dataAddr,
  output logic [dataWidth-1:0]     dataWdata,
  output logic                     dataWrite,
  input  logic [dataWidth-1:0]     dataRdata,
  // register write port, observation only
  output logic                     regWriteEn,
  output logic [regAddrWidth-1:0]  regWriteAddr,
  output logic [dataWidth-1:0]     regWriteData
);

  logic [regAddrWidth-1:0] rsAddr;
  logic [regAddrWidth-1:0] rtAddr;
  logic [dataWidth-1:0]    rsData;
  logic [dataWidth-1:0]    rtData;
  logic [dataWidth-1:0]    aluResult;
  logic [dataWidth-1:0]    wrData;
  logic [dataWidth-1:0]    linkAddr;
  logic                    zero;

  decodeIf decBus ();

  // source register fields
  assign rsAddr = instr[rsMsb:rsLsb];
  assign rtAddr = instr[rtMsb:rtLsb];

  //====================================================================
  // fetch, decode, register file, execute
  //====================================================================
  controlDecoder decoder_i (.instr(instr), .dec(decBus));

  pcUnit pcUnit_i (
    .clk(clk), .rst(rst), .dec(decBus), .zero(zero),
    .rsData(rsData), .pc(instrAddr), .linkAddr(linkAddr)
  );

  regFile regFile_i (
    .clk(clk), .rst(rst), .dec(decBus), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .wrData(wrData), .rsData(rsData), .rtData(rtData)
  );

  executeUnit execute_i (
    .dec(decBus), .rsData(rsData), .rtData(rtData), .memRdata(dataRdata),
    .linkAddr(linkAddr), .aluResult(aluResult), .wrData(wrData), .zero(zero)
  );

  // byte address to word address
  assign dataAddr     = aluResult[dmemAddrWidth+1:2];
  assign dataWdata    = rtData;
  assign dataWrite    = decBus.memWrite;
  assign regWriteEn   = decBus.regWrite;
  assign regWriteAddr = decBus.destReg;
  assign regWriteData = wrData;

endmodule

// ==== mipsCore_asserts.sv ====
//======================================================================
// bound assertions: write enables and fetch alignment
//======================================================================
`timescale 1ns/100ps

module mipsCore_asserts
  import mipsIsaPkg::*;
(
  input logic                    clk,
  input logic                    rst,
  input logic                    dataWrite,
  input logic                    regWriteEn,
  input logic [regAddrWidth-1:0] regWriteAddr,
  input logic [dataWidth-1:0]    instrAddr
);

  int assertFails = 0;

  // no instruction stores and writes a register at once
  writeExclusive: assert property (@(posedge clk) disable iff (!rst)
    !(dataWrite && regWriteEn))
    else begin
      assertFails++;
      $error("dataWrite and regWriteEn high in the same cycle");
    end

  // r0 writes are masked in the decoder
  noR0Write: assert property (@(posedge clk) disable iff (!rst)
    regWriteEn |-> (regWriteAddr != '0))
    else begin
      assertFails++;
      $error("register write aimed at r0");
    end

  wordAligned: assert property (@(posedge clk) disable iff (!rst)
    instrAddr[1:0] == 2'b00)
    else begin
      assertFails++;
      $error("instrAddr not word aligned");
    end

endmodule

bind mipsCore mipsCore_asserts asserts_i (
  .clk(clk), .rst(rst), .dataWrite(dataWrite), .regWriteEn(regWriteEn),
  .regWriteAddr(regWriteAddr), .instrAddr(instrAddr)
);

// ==== mipsCtrlPkg.sv ====
//======================================================================
// core control encodings: ALU operation and write-back source
//======================================================================
package mipsCtrlPkg;

  localparam int aluOpWidth = 3;
  localparam int wbSrcWidth = 2;

  // ALU function, resolved from opcode and funct
  typedef enum logic [aluOpWidth-1:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    // unsigned compare, 1 or 0
    aluSlt
  } aluOpT;

  // register write data source
  typedef enum logic [wbSrcWidth-1:0] {
    wbAlu,
    wbMem,
    // pc+8 for jal
    wbLink
  } wbSrcT;

endpackage

// ==== mipsIsaPkg.sv ====
//======================================================================
// MIPS subset instruction set: widths, field positions, opcode and
// funct encodings
//======================================================================
package mipsIsaPkg;

  // datapath and storage widths
  localparam int dataWidth     = 32;
  localparam int regAddrWidth  = 5;
  localparam int numRegs       = 1 << regAddrWidth;
  localparam int dmemAddrWidth = 7;
  localparam int immWidth      = 16;
  localparam int targetWidth   = 26;
  localparam int opWidth       = 6;
  localparam int fnWidth       = 6;

  // jal return address goes here
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  //====================================================================
  // instruction field positions
  //====================================================================
  localparam int opMsb = 31;
  localparam int opLsb = 26;
  localparam int rsMsb = 25;
  localparam int rsLsb = 21;
  localparam int rtMsb = 20;
  localparam int rtLsb = 16;
  localparam int rdMsb = 15;
  localparam int rdLsb = 11;
  localparam int fnMsb = 5;
  localparam int fnLsb = 0;

  // primary opcodes
  localparam logic [opWidth-1:0] opR   = 6'b000000;
  localparam logic [opWidth-1:0] opLw  = 6'b100011;
  localparam logic [opWidth-1:0] opSw  = 6'b101011;
  localparam logic [opWidth-1:0] opBeq = 6'b000100;
  localparam logic [opWidth-1:0] opJ   = 6'b000010;
  localparam logic [opWidth-1:0] opJal = 6'b000011;

  // funct field, R-type only
  localparam logic [fnWidth-1:0] fnAdd = 6'b100000;
  localparam logic [fnWidth-1:0] fnSub = 6'b100010;
  localparam logic [fnWidth-1:0] fnAnd = 6'b100100;
  localparam logic [fnWidth-1:0] fnOr  = 6'b100101;
  localparam logic [fnWidth-1:0] fnSlt = 6'b101010;
  localparam logic [fnWidth-1:0] fnJr  = 6'b001000;

endpackage

// ==== pcUnit.sv ====
//======================================================================
// program counter and next address select
//======================================================================
`timescale 1ns/100ps

module pcUnit
  import mipsIsaPkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  decodeIf.fetch               dec,
  input  logic                 zero,
  input  logic [dataWidth-1:0] rsData,
  output logic [dataWidth-1:0] pc,
  output logic [dataWidth-1:0] linkAddr
);

  logic [dataWidth-1:0] pcReg;
  logic [dataWidth-1:0] pcPlus4;
  logic [dataWidth-1:0] branchOffset;
  logic [dataWidth-1:0] branchAddr;
  logic [dataWidth-1:0] jumpAddr;

  assign pcPlus4  = pcReg + 32'd4;
  // jal saves pc+8
  assign linkAddr = pcReg + 32'd8;

  // word offset, sign extended then scaled to bytes
  assign branchOffset = {{(dataWidth-immWidth-2){dec.imm16[immWidth-1]}},
                         dec.imm16, 2'b00};
  assign branchAddr   = pcPlus4 + branchOffset;

  // region bits stay from pc+4
  assign jumpAddr = {pcPlus4[dataWidth-1:dataWidth-4], dec.target26, 2'b00};

  //====================================================================
  // pc register, jr over j/jal over taken beq
  //====================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= '0;
    end else if (dec.jumpReg) begin
      pcReg <= rsData;
    end else if (dec.jump) begin
      pcReg <= jumpAddr;
    end else if (dec.branch && zero) begin
      pcReg <= branchAddr;
    end else begin
      pcReg <= pcPlus4;
    end
  end

  assign pc = pcReg;

endmodule

// ==== regFile.sv ====
//======================================================================
// 32 x 32 register file, two async reads, one sync write
//======================================================================
`timescale 1ns/100ps

module regFile
  import mipsIsaPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  decodeIf.regs                   dec,
  input  logic [regAddrWidth-1:0] rsAddr,
  input  logic [regAddrWidth-1:0] rtAddr,
  input  logic [dataWidth-1:0]    wrData,
  output logic [dataWidth-1:0]    rsData,
  output logic [dataWidth-1:0]    rtData
);

  logic [dataWidth-1:0] regs [numRegs];

  //====================================================================
  // write port and reset clear
  //====================================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (dec.regWrite) begin
      // decoder never raises regWrite for r0
      regs[dec.destReg] <= wrData;
    end
  end

  // r0 reads as zero on both ports
  assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

// ==== sim.f ====
mipsIsaPkg.sv
mipsCtrlPkg.sv
decodeIf.sv
pcUnit.sv
controlDecoder.sv
regFile.sv
executeUnit.sv
mipsCore.sv
mipsCore_asserts.sv
tbMipsCore.sv

// ==== tbMipsCore.sv ====
//======================================================================
// testbench: instruction and data memories, random program generator,
// reference instruction model, checks and cycle timeout
//======================================================================
`timescale 1ns/100ps

module tbMipsCore
  import mipsIsaPkg::*;
();

  localparam int halfPeriod  = 4;
  localparam int resetCycles = 4;
  localparam int numInstr    = 400;
  localparam int dmemWords   = 1 << dmemAddrWidth;
  // program layout: body loops back from bodyEnd, then subroutine, readback, halt
  localparam int bodyEnd     = 39;
  localparam int subStart    = 40;
  localparam int readStart   = 43;
  localparam int haltIdx     = 51;
  // last body pass, subroutine calls and readback fit in the margin
  localparam int maxCycles   = resetCycles + numInstr + 96;

  logic                     clk;
  logic                     rst;
  logic [dataWidth-1:0]     instrAddr, instr, dataWdata, dataRdata, regWriteData;
  logic [dmemAddrWidth-1:0] dataAddr;
  logic                     dataWrite, regWriteEn;
  logic [regAddrWidth-1:0]  regWriteAddr;

  logic [dataWidth-1:0] imem [64];
  logic [dataWidth-1:0] dmem [dmemWords];
  // reference model state
  logic [dataWidth-1:0] mRegs [numRegs];
  logic [dataWidth-1:0] mMem [dmemWords];
  logic [dataWidth-1:0] mPc;
  logic [5:0]           aluFns [5];
  integer               seed;
  int                   errors, cycles, retired;
  bit                   patched;

  mipsCore dut_i (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr), .dataAddr(dataAddr),
    .dataWdata(dataWdata), .dataWrite(dataWrite), .dataRdata(dataRdata),
    .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
  );

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  // combinational read, a single-cycle lw needs it within the cycle
  assign dataRdata = dmem[dataAddr];

  always @(posedge clk) begin
    if (dataWrite) begin
      dmem[dataAddr] <= dataWdata;
    end
  end

  //====================================================================
  // instruction encoding and program generation
  //====================================================================
  function automatic int pickBelow(int n);
    return {$random(seed)} % n;
  endfunction

  function automatic logic [31:0] rTypeWord(int rs, int rt, int rd, logic [5:0] fn);
    return {opR, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic logic [31:0] iTypeWord(logic [5:0] op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] jTypeWord(logic [5:0] op, int target);
    return {op, target[25:0]};
  endfunction

  task automatic buildProgram();
    int kind;
    int rs;
    int rt;
    int rd;
    int off;
    for (int w = 0; w < 64; w++) begin
      imem[w] = '0;
    end
    // body: forward-only branches and jumps, r0..r7
    for (int i = 0; i < bodyEnd; i++) begin
      kind = pickBelow(10);
      rs   = pickBelow(8);
      rt   = pickBelow(8);
      rd   = pickBelow(8);
      off  = pickBelow(16);
      // return address pc+8 has to stay inside the body
      if (kind == 9 && i > bodyEnd - 2) begin
        kind = 0;
      end
      case (kind)
        5: imem[i] = iTypeWord(opLw, rs, rt, off * 4);
        6: imem[i] = iTypeWord(opSw, rs, rt, off * 4);
        7: begin
          // same register half the time, so beq is taken often
          if (off[0]) begin
            rt = rs;
          end
          imem[i] = iTypeWord(opBeq, rs, rt, pickBelow(bodyEnd - i));
        end
        8: imem[i] = jTypeWord(opJ, i + 1 + pickBelow(bodyEnd - i));
        9: imem[i] = jTypeWord(opJal, subStart);
        default: imem[i] = rTypeWord(rs, rt, rd, aluFns[kind % 5]);
      endcase
    end
    imem[bodyEnd] = jTypeWord(opJ, 0);
    // subroutine: two ALU ops, return through r31
    for (int i = subStart; i < subStart + 2; i++) begin
      rs = pickBelow(8);
      rt = pickBelow(8);
      rd = pickBelow(8);
      imem[i] = rTypeWord(rs, rt, rd, aluFns[pickBelow(5)]);
    end
    imem[subStart + 2] = rTypeWord(linkReg, 0, 0, fnJr);
    // readback of r1..r7 and r31, then a self loop
    for (int k = 1; k < 8; k++) begin
      imem[readStart + k - 1] = iTypeWord(opSw, 0, k, (96 + k) * 4);
    end
    imem[readStart + 7] = iTypeWord(opSw, 0, linkReg, 104 * 4);
    imem[haltIdx] = jTypeWord(opJ, haltIdx);
  endtask

  //====================================================================
  // checks and reference model
  //====================================================================
  task automatic compareWord(string name, logic [31:0] expVal, logic [31:0] actVal);
    if (actVal !== expVal) begin
      $display("[ERROR] %s at pc %h: expected %h, actual %h", name, mPc, expVal, actVal);
      errors++;
    end
  endtask

  task automatic stepModel();
    logic [5:0]               op;
    logic [5:0]               fn;
    logic [regAddrWidth-1:0]  rs, rt, rd, wDest;
    logic [dataWidth-1:0]     rsV, rtV, seImm, pc4, pcNext, wData, addr;
    logic [dmemAddrWidth-1:0] mAddr;
    logic                     wEn, mEn;
    op     = instr[31:26];
    fn     = instr[5:0];
    rs     = instr[25:21];
    rt     = instr[20:16];
    rd     = instr[15:11];
    rsV    = mRegs[rs];
    rtV    = mRegs[rt];
    seImm  = {{16{instr[15]}}, instr[15:0]};
    pc4    = mPc + 4;
    pcNext = pc4;
    wEn    = 1'b0;
    mEn    = 1'b0;
    wDest  = rd;
    wData  = '0;
    // lw/sw word address
    addr   = rsV + seImm;
    mAddr  = addr[8:2];
    case (op)
      opR: begin
        wEn = 1'b1;
        case (fn)
          fnAdd: wData = rsV + rtV;
          fnSub: wData = rsV - rtV;
          fnAnd: wData = rsV & rtV;
          fnOr:  wData = rsV | rtV;
          fnSlt: wData = (rsV < rtV) ? 32'd1 : 32'd0;
          default: wEn = 1'b0;
        endcase
        if (fn == fnJr) begin
          pcNext = rsV;
        end
      end
      opLw: begin
        wEn   = 1'b1;
        wDest = rt;
        wData = mMem[mAddr];
      end
      opSw: mEn = 1'b1;
      opBeq: begin
        if (rsV == rtV) begin
          pcNext = pc4 + (seImm << 2);
        end
      end
      opJ, opJal: pcNext = {pc4[31:28], instr[25:0], 2'b00};
      default: ;
    endcase
    if (op == opJal) begin
      wEn   = 1'b1;
      wDest = linkReg;
      wData = mPc + 8;
    end
    // r0 never written, so reads of it stay zero
    if (wDest == '0) begin
      wEn = 1'b0;
    end
    compareWord("regWriteEn", wEn, regWriteEn);
    if (wEn) begin
      compareWord("regWriteAddr", wDest, regWriteAddr);
      compareWord("regWriteData", wData, regWriteData);
    end
    compareWord("dataWrite", mEn, dataWrite);
    if (mEn) begin
      compareWord("dataAddr", mAddr, dataAddr);
      compareWord("dataWdata", rtV, dataWdata);
    end
    if (wEn) begin
      mRegs[wDest] = wData;
    end
    if (mEn) begin
      mMem[mAddr] = rtV;
    end
    mPc = pcNext;
  endtask

  //====================================================================
  // main sequence
  //====================================================================
  initial begin
    seed    = 18854;
    errors  = 0;
    retired = 0;
    patched = 1'b0;
    rst     = 1'b0;
    // nop while in reset
    instr   = '0;
    mPc     = '0;
    aluFns  = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};
    for (int a = 0; a < dmemWords; a++) begin
      dmem[a] = '0;
      mMem[a] = '0;
    end
    for (int r = 0; r < numRegs; r++) begin
      mRegs[r] = '0;
    end
    buildProgram();
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    while (!(patched && mPc == haltIdx * 4)) begin
      compareWord("instrAddr", mPc, instrAddr);
      instr = imem[instrAddr[7:2]];
      #1;
      stepModel();
      retired++;
      if (retired == numInstr) begin
        // loop-back jump now leads into the readback block
        imem[bodyEnd] = jTypeWord(opJ, readStart);
        patched = 1'b1;
      end
      @(negedge clk);
    end
    for (int a = 0; a < dmemWords; a++) begin
      compareWord("dmem", mMem[a], dmem[a]);
    end
    $display("%0d instructions, %0d check errors, %0d assertion failures",
             retired, errors, dut_i.asserts_i.assertFails);
    if (errors == 0 && dut_i.asserts_i.assertFails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycles = 0;
    while (cycles < maxCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: core did not reach the halt loop within %0d cycles", maxCycles);
    $display("Test FAILED");
    $finish;
  end

endmodule
